//--- bench/surf_ctrl_tb_tasks.svh
`ifndef SURF_CTRL_TB_TASKS_SVH
`define SURF_CTRL_TB_TASKS_SVH

// Response compare, names the master port that was checked.
task automatic check_rsp(input string name, input surf_ctrl_pkg::wb_rsp_t exp,
		input surf_ctrl_pkg::wb_rsp_t act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("FAILED %s: expected ack=%h err=%h dat=%h, got ack=%h err=%h dat=%h",
			name, exp.ack, exp.err, exp.dat, act.ack, act.err, act.dat);
	end
endtask

// Front-panel LEDs against the model.
task automatic check_led(input logic [`LED_W-1:0] exp, input logic [`LED_W-1:0] act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("FAILED led_o: expected %h, got %h", exp, act);
	end
endtask

// Trace record rebuilt from a head and a data read.
task automatic check_rec(input surf_ctrl_pkg::trace_rec_t exp,
		input surf_ctrl_pkg::trace_rec_t act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("FAILED trace record: expected mid=%h we=%h err=%h adr=%h dat=%h, %s%h%s%h%s%h%s%h%s%h",
			exp.mid, exp.we, exp.err, exp.adr, exp.dat,
			"got mid=", act.mid, " we=", act.we, " err=", act.err,
			" adr=", act.adr, " dat=", act.dat);
	end
endtask

// Master 0 cycle.
// Called just after a rising edge; returns one idle cycle after the drop.
task automatic m0_access(input surf_ctrl_pkg::wb_req_t req,
		output surf_ctrl_pkg::wb_rsp_t rsp);
	m0_req = req;
	do begin
		@(negedge sys_clk);
		rsp = m0_rsp;
	end while (!(rsp.ack || rsp.err));
	@(posedge sys_clk);
	#1;
	m0_req = '0;
	@(posedge sys_clk);
	#1;
endtask

// Master 1 cycle, same handshake.
task automatic m1_access(input surf_ctrl_pkg::wb_req_t req,
		output surf_ctrl_pkg::wb_rsp_t rsp);
	m1_req = req;
	do begin
		@(negedge sys_clk);
		rsp = m1_rsp;
	end while (!(rsp.ack || rsp.err));
	@(posedge sys_clk);
	#1;
	m1_req = '0;
	@(posedge sys_clk);
	#1;
endtask

`endif

//--- bench/surf_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "surf_ctrl_config.svh"

module surf_ctrl_tb;

	localparam int N_REG = 12;
	localparam int N_UNMAPPED = 6;
	localparam int N_ROUNDS = 4;
	localparam int N_PER_MASTER = 6;
	localparam int N_OVF = 20;
	// Five fixed accesses plus one drain per phase and per round.
	localparam int XFER_PLAN = 5 + N_REG + N_UNMAPPED + 2 * N_ROUNDS * N_PER_MASTER + N_OVF +
		(4 + N_ROUNDS) * (2 * `TRACE_DEPTH + 3);
	localparam int CYCLE_LIMIT = 40 * XFER_PLAN + 100;

	logic sys_clk = 1'b0;
	logic rst_n;
	surf_ctrl_pkg::wb_req_t m0_req;
	surf_ctrl_pkg::wb_req_t m1_req;
	surf_ctrl_pkg::wb_rsp_t m0_rsp;
	surf_ctrl_pkg::wb_rsp_t m1_rsp;
	logic [`LED_W-1:0] led;

	// Reference model.
	logic [`WB_DAT_W-1:0] scratch_m;
	logic [`LED_W-1:0] led_m;
	logic ovf_m;
	surf_ctrl_pkg::trace_rec_t trace_q[$];

	int n_checks = 0;
	int n_errors = 0;
	int cycle_cnt = 0;

	`include "surf_ctrl_tb_tasks.svh"

	surf_ctrl_top u_dut (
		.sys_clk  (sys_clk),
		.rst_n_i  (rst_n),
		.m0_req_i (m0_req),
		.m0_rsp_o (m0_rsp),
		.m1_req_i (m1_req),
		.m1_rsp_o (m1_rsp),
		.led_o    (led)
	);

	// 125 MHz.
	always #4 sys_clk = ~sys_clk;

	// Run limit.
	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d", n_checks, n_errors);
			$display("Errors found");
			$finish;
		end
	end

	// A response must go to a master with an open cycle, and never to both.
	always @(negedge sys_clk) begin
		if (rst_n) begin
			if ((m0_rsp.ack || m0_rsp.err) && !m0_req.cyc) begin
				n_errors++;
				$display("Master 0 got a response without an open cycle");
			end
			if ((m1_rsp.ack || m1_rsp.err) && !m1_req.cyc) begin
				n_errors++;
				$display("Master 1 got a response without an open cycle");
			end
			if ((m0_rsp.ack || m0_rsp.err) && (m1_rsp.ack || m1_rsp.err)) begin
				n_errors++;
				$display("Both masters got a response in the same cycle");
			end
		end
	end

	// Address in a slave field with random bits between field and word offset.
	function automatic logic [`WB_ADR_W-1:0] build_adr(input logic [3:0] field,
			input logic [1:0] off);
		return {field, (`SLV_FIELD_LO-4)'($urandom), off, 2'b00};
	endfunction

	// Expected response of one finished transfer; updates the model.
	task automatic predict(input bit mid, input surf_ctrl_pkg::wb_req_t req,
			output surf_ctrl_pkg::wb_rsp_t exp);
		logic [3:0] field;
		logic [1:0] off;
		surf_ctrl_pkg::trace_rec_t rec;
		surf_ctrl_pkg::trace_rec_t head;
		field = req.adr[`SLV_FIELD_HI:`SLV_FIELD_LO];
		off = req.adr[3:2];
		exp = '0;
		if (field == `SLV_ID_CTRL_BASE) begin
			exp.ack = 1'b1;
			if (req.we && off == surf_ctrl_pkg::REG_SCRATCH) begin
				for (int i = 0; i < `WB_SEL_W; i++)
					if (req.sel[i])
						scratch_m[8*i +: 8] = req.dat[8*i +: 8];
			end else if (req.we && off == surf_ctrl_pkg::REG_LED && req.sel[0]) begin
				led_m = req.dat[`LED_W-1:0];
			end else if (!req.we) begin
				case (off)
					surf_ctrl_pkg::REG_VERSION: exp.dat = `FW_VERSION;
					surf_ctrl_pkg::REG_SCRATCH: exp.dat = scratch_m;
					surf_ctrl_pkg::REG_LED:     exp.dat = {{(`WB_DAT_W-`LED_W){1'b0}}, led_m};
					default:                    exp.dat = '0;
				endcase
			end
		end else if (field == `SLV_TRACE_BASE) begin
			exp.ack = 1'b1;
			if (req.we && off == surf_ctrl_pkg::TRC_STATUS)
				ovf_m = 1'b0;
			else if (!req.we && off == surf_ctrl_pkg::TRC_STATUS)
				exp.dat = {ovf_m, {(`WB_DAT_W-`TRACE_PTR_W-2){1'b0}},
					(`TRACE_PTR_W+1)'(trace_q.size())};
			else if (!req.we && off == surf_ctrl_pkg::TRC_HEAD && trace_q.size() > 0)
				exp.dat = {trace_q[0].mid, trace_q[0].we, trace_q[0].err,
					{(`WB_DAT_W-3-`WB_ADR_W){1'b0}}, trace_q[0].adr};
			else if (!req.we && off == surf_ctrl_pkg::TRC_DATA && trace_q.size() > 0) begin
				head = trace_q.pop_front();
				exp.dat = head.dat;
			end
		end else begin
			exp.err = 1'b1;
		end
		// Everything outside the trace window is recorded.
		// The oldest are kept on overflow.
		if (field != `SLV_TRACE_BASE) begin
			rec.mid = mid;
			rec.we = req.we;
			rec.err = exp.err;
			rec.adr = req.adr;
			rec.dat = req.we ? req.dat : exp.dat;
			if (trace_q.size() < `TRACE_DEPTH)
				trace_q.push_back(rec);
			else
				ovf_m = 1'b1;
		end
	endtask

	// One checked transfer from either master.
	task automatic xfer(input bit mid, input logic we, input logic [`WB_ADR_W-1:0] adr,
			input logic [`WB_SEL_W-1:0] sel, input logic [`WB_DAT_W-1:0] wdat,
			output surf_ctrl_pkg::wb_rsp_t rsp);
		surf_ctrl_pkg::wb_req_t req;
		surf_ctrl_pkg::wb_rsp_t exp;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = adr;
		req.sel = sel;
		req.dat = wdat;
		if (mid)
			m1_access(req, rsp);
		else
			m0_access(req, rsp);
		predict(mid, req, exp);
		check_rsp(mid ? "m1_rsp_o" : "m0_rsp_o", exp, rsp);
		check_led(led_m, led);
	endtask

	// Check the status, read back every record and clear overflow.
	task automatic drain_trace();
		surf_ctrl_pkg::wb_rsp_t rsp;
		surf_ctrl_pkg::wb_rsp_t hrsp;
		surf_ctrl_pkg::trace_rec_t exp_rec;
		surf_ctrl_pkg::trace_rec_t act_rec;
		int n;
		// Capture and FIFO write trail the last ack.
		repeat (3) @(posedge sys_clk);
		#1;
		xfer(1'b0, 1'b0, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_STATUS),
			'1, '0, rsp);
		n = trace_q.size();
		repeat (n) begin
			exp_rec = trace_q[0];
			xfer(1'b0, 1'b0, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_HEAD),
				'1, '0, hrsp);
			xfer(1'b0, 1'b0, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_DATA),
				'1, '0, rsp);
			act_rec.mid = hrsp.dat[31];
			act_rec.we = hrsp.dat[30];
			act_rec.err = hrsp.dat[29];
			act_rec.adr = hrsp.dat[`WB_ADR_W-1:0];
			act_rec.dat = rsp.dat;
			check_rec(exp_rec, act_rec);
		end
		xfer(1'b0, 1'b1, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_STATUS),
			'1, '0, rsp);
		xfer(1'b0, 1'b0, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_STATUS),
			'1, '0, rsp);
	endtask

	// Random mix of register and unmapped accesses with random gaps.
	task automatic master_traffic(input bit mid);
		surf_ctrl_pkg::wb_rsp_t rsp;
		logic [3:0] field;
		int gap;
		repeat (N_PER_MASTER) begin
			gap = $urandom_range(3);
			repeat (gap) begin
				@(posedge sys_clk);
				#1;
			end
			if ($urandom_range(4) == 0)
				field = 4'($urandom_range(15, 2));
			else
				field = 4'(`SLV_ID_CTRL_BASE);
			xfer(mid, 1'($urandom), build_adr(field, 2'($urandom)), 4'($urandom),
				$urandom, rsp);
		end
	endtask

	initial begin
		surf_ctrl_pkg::wb_rsp_t rsp;
		void'($urandom(30399));
		rst_n = 1'b0;
		m0_req = '0;
		m1_req = '0;
		scratch_m = '0;
		led_m = '0;
		ovf_m = 1'b0;
		repeat (3) @(posedge sys_clk);
		#1;
		rst_n = 1'b1;
		@(posedge sys_clk);
		#1;

		// Version word is read only.
		xfer(1'b0, 1'b0, build_adr(4'(`SLV_ID_CTRL_BASE), surf_ctrl_pkg::REG_VERSION),
			'1, '0, rsp);
		xfer(1'b0, 1'b1, build_adr(4'(`SLV_ID_CTRL_BASE), surf_ctrl_pkg::REG_VERSION),
			'1, $urandom, rsp);
		xfer(1'b0, 1'b0, build_adr(4'(`SLV_ID_CTRL_BASE), surf_ctrl_pkg::REG_VERSION),
			'1, '0, rsp);
		drain_trace();

		// Scratch and LED with random byte selects.
		repeat (N_REG)
			xfer(1'b0, ($urandom_range(2) != 0),
				build_adr(4'(`SLV_ID_CTRL_BASE), 2'($urandom_range(2, 1))),
				4'($urandom), $urandom, rsp);
		drain_trace();

		// Unmapped slave fields.
		repeat (N_UNMAPPED)
			xfer(1'b0, 1'($urandom), build_adr(4'($urandom_range(15, 2)), 2'($urandom)),
				'1, $urandom, rsp);
		drain_trace();

		// Both masters at once.
		repeat (N_ROUNDS) begin
			fork
				master_traffic(1'b0);
				master_traffic(1'b1);
			join
			drain_trace();
		end

		// Overflow keeps the oldest records.
		repeat (N_OVF)
			xfer(1'b0, 1'b1, build_adr(4'(`SLV_ID_CTRL_BASE), surf_ctrl_pkg::REG_SCRATCH),
				'1, $urandom, rsp);
		drain_trace();

		// Empty trace reads zero and stays empty.
		xfer(1'b0, 1'b0, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_DATA),
			'1, '0, rsp);
		xfer(1'b0, 1'b0, build_adr(4'(`SLV_TRACE_BASE), surf_ctrl_pkg::TRC_STATUS),
			'1, '0, rsp);

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
+incdir+bench
verilog/surf_ctrl_pkg.sv
verilog/wbc_intercon.sv
verilog/id_ctrl_regs.sv
verilog/wb_trace_capture.sv
verilog/trace_fifo.sv
verilog/trace_reader.sv
verilog/surf_ctrl_top.sv
bench/surf_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module surf_ctrl_tb -f compile.f \
	> build.log 2>&1 \
	&& ./obj_dir/Vsurf_ctrl_tb > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0

//--- verilog/id_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "surf_ctrl_config.svh"

module id_ctrl_regs (
	input  wire                          sys_clk,
	input  wire                          rst_n_i,
	input  wire surf_ctrl_pkg::wb_req_t  wb_req_i,
	output surf_ctrl_pkg::wb_rsp_t       wb_rsp_o,
	output logic [`LED_W-1:0]            led_o
);

	surf_ctrl_pkg::id_reg_e reg_off;
	logic req_new;
	logic ack_q;
	logic [`WB_DAT_W-1:0] rd_dat;
	logic [`WB_DAT_W-1:0] dat_q;
	logic [`WB_DAT_W-1:0] scratch_q;
	logic [`LED_W-1:0] led_q;

	// A new access is one not yet acknowledged.
	assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	assign reg_off = surf_ctrl_pkg::id_reg_e'(wb_req_i.adr[3:2]);

	// Read mux.
	always_comb begin
		case (reg_off)
			surf_ctrl_pkg::REG_VERSION: rd_dat = `FW_VERSION;
			surf_ctrl_pkg::REG_SCRATCH: rd_dat = scratch_q;
			surf_ctrl_pkg::REG_LED:     rd_dat = {{(`WB_DAT_W-`LED_W){1'b0}}, led_q};
			default:                    rd_dat = '0;
		endcase
	end

	// Registered ack, one cycle after stb.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req_new;
	end

	// Read data captured with the ack.
	always_ff @(posedge sys_clk) begin
		if (req_new)
			dat_q <= wb_req_i.we ? '0 : rd_dat;
	end

	// Writable registers.
	// Scratch honours every byte lane, LED lives in lane 0.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			scratch_q <= '0;
			led_q <= '0;
		end else if (req_new && wb_req_i.we) begin
			case (reg_off)
				surf_ctrl_pkg::REG_SCRATCH: begin
					for (int i = 0; i < `WB_SEL_W; i++) begin
						if (wb_req_i.sel[i])
							scratch_q[8*i +: 8] <= wb_req_i.dat[8*i +: 8];
					end
				end
				surf_ctrl_pkg::REG_LED: begin
					if (wb_req_i.sel[0])
						led_q <= wb_req_i.dat[`LED_W-1:0];
				end
				default: ;
			endcase
		end
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.err = 1'b0;
	assign wb_rsp_o.dat = ack_q ? dat_q : '0;
	assign led_o = led_q;

endmodule

`default_nettype wire

//--- verilog/surf_ctrl_config.svh
`ifndef SURF_CTRL_CONFIG_SVH
`define SURF_CTRL_CONFIG_SVH

// Control bus geometry. The register space is 20 bits of byte address.
`define WB_ADR_W 20
`define WB_DAT_W 32
`define WB_SEL_W 4

// Address map. The top nibble of the address picks the slave.
`define SLV_FIELD_HI 19
`define SLV_FIELD_LO 16
`define SLV_ID_CTRL_BASE 0
`define SLV_TRACE_BASE 1

// Trace buffer size, depth must be a power of two.
`define TRACE_DEPTH 16
`define TRACE_PTR_W 4

// Firmware version fields.
`define FW_BOARDREV 4'h1
`define FW_MONTH 4'd6
`define FW_DAY 8'd10
`define FW_MAJOR 4'd0
`define FW_MINOR 4'd2
`define FW_REVISION 8'd6
`define FW_VERSION {`FW_BOARDREV, `FW_MONTH, `FW_DAY, `FW_MAJOR, `FW_MINOR, `FW_REVISION}

// Front-panel LED register width.
`define LED_W 4

`endif

//--- verilog/surf_ctrl_pkg.sv
`default_nettype none

`include "surf_ctrl_config.svh"

package surf_ctrl_pkg;

	// Master side of a Wishbone classic cycle.
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`WB_ADR_W-1:0] adr;
		logic [`WB_SEL_W-1:0] sel;
		logic [`WB_DAT_W-1:0] dat;
	} wb_req_t;

	// Slave side. Data is zero unless ack is high.
	typedef struct packed {
		logic                 ack;
		logic                 err;
		logic [`WB_DAT_W-1:0] dat;
	} wb_rsp_t;

	// Decoded target of the granted request.
	typedef enum logic [1:0] {
		SLV_ID_CTRL = 2'd0,
		SLV_TRACE   = 2'd1,
		SLV_NONE    = 2'd2
	} slave_sel_e;

	// Current bus owner.
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_M0   = 2'd1,
		ARB_M1   = 2'd2
	} arb_state_e;

	// Word offsets, address bits 3:2.
	typedef enum logic [1:0] {
		REG_VERSION = 2'd0,
		REG_SCRATCH = 2'd1,
		REG_LED     = 2'd2
	} id_reg_e;

	typedef enum logic [1:0] {
		TRC_HEAD   = 2'd0,
		TRC_DATA   = 2'd1,
		TRC_STATUS = 2'd2
	} trace_reg_e;

	// One finished transfer as seen by the interconnect.
	typedef struct packed {
		logic                 valid;
		logic                 mid;
		slave_sel_e           target;
		logic                 we;
		logic                 err;
		logic [`WB_ADR_W-1:0] adr;
		logic [`WB_DAT_W-1:0] dat;
	} bus_mon_t;

	// What the trace buffer keeps of it.
	typedef struct packed {
		logic                 mid;
		logic                 we;
		logic                 err;
		logic [`WB_ADR_W-1:0] adr;
		logic [`WB_DAT_W-1:0] dat;
	} trace_rec_t;

endpackage

`default_nettype wire

//--- verilog/surf_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "surf_ctrl_config.svh"

module surf_ctrl_top (
	input  wire                          sys_clk,
	input  wire                          rst_n_i,
	input  wire surf_ctrl_pkg::wb_req_t  m0_req_i,
	output surf_ctrl_pkg::wb_rsp_t       m0_rsp_o,
	input  wire surf_ctrl_pkg::wb_req_t  m1_req_i,
	output surf_ctrl_pkg::wb_rsp_t       m1_rsp_o,
	output logic [`LED_W-1:0]            led_o
);

	// Slave ports.
	surf_ctrl_pkg::wb_req_t id_req;
	surf_ctrl_pkg::wb_rsp_t id_rsp;
	surf_ctrl_pkg::wb_req_t trace_req;
	surf_ctrl_pkg::wb_rsp_t trace_rsp;

	// Trace chain.
	surf_ctrl_pkg::bus_mon_t mon;
	surf_ctrl_pkg::trace_rec_t cap_rec;
	surf_ctrl_pkg::trace_rec_t head_rec;
	logic cap_push;
	logic rd_pop;
	logic ovf_clr;
	logic ovf;
	logic [`TRACE_PTR_W:0] count;

	// Shared bus with fixed priority, m0 first.
	wbc_intercon u_intercon (
		.sys_clk     (sys_clk),
		.rst_n_i     (rst_n_i),
		.m0_req_i    (m0_req_i),
		.m1_req_i    (m1_req_i),
		.m0_rsp_o    (m0_rsp_o),
		.m1_rsp_o    (m1_rsp_o),
		.id_req_o    (id_req),
		.id_rsp_i    (id_rsp),
		.trace_req_o (trace_req),
		.trace_rsp_i (trace_rsp),
		.mon_o       (mon)
	);

	// ID and control block at 0x00000.
	id_ctrl_regs u_id_ctrl (
		.sys_clk  (sys_clk),
		.rst_n_i  (rst_n_i),
		.wb_req_i (id_req),
		.wb_rsp_o (id_rsp),
		.led_o    (led_o)
	);

	// Producer side of the trace.
	wb_trace_capture u_capture (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.mon_i   (mon),
		.rec_o   (cap_rec),
		.push_o  (cap_push)
	);

	trace_fifo u_fifo (
		.sys_clk   (sys_clk),
		.rst_n_i   (rst_n_i),
		.push_i    (cap_push),
		.rec_i     (cap_rec),
		.pop_i     (rd_pop),
		.head_o    (head_rec),
		.count_o   (count),
		.ovf_clr_i (ovf_clr),
		.ovf_o     (ovf)
	);

	// Trace window at 0x10000.
	trace_reader u_reader (
		.sys_clk   (sys_clk),
		.rst_n_i   (rst_n_i),
		.wb_req_i  (trace_req),
		.wb_rsp_o  (trace_rsp),
		.head_i    (head_rec),
		.count_i   (count),
		.ovf_i     (ovf),
		.pop_o     (rd_pop),
		.ovf_clr_o (ovf_clr)
	);

endmodule

`default_nettype wire

//--- verilog/trace_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "surf_ctrl_config.svh"

module trace_fifo (
	input  wire                             sys_clk,
	input  wire                             rst_n_i,
	input  wire                             push_i,
	input  wire surf_ctrl_pkg::trace_rec_t  rec_i,
	input  wire                             pop_i,
	output surf_ctrl_pkg::trace_rec_t       head_o,
	output logic [`TRACE_PTR_W:0]           count_o,
	input  wire                             ovf_clr_i,
	output logic                            ovf_o
);

	surf_ctrl_pkg::trace_rec_t mem [`TRACE_DEPTH];
	logic [`TRACE_PTR_W-1:0] wr_ptr_q;
	logic [`TRACE_PTR_W-1:0] rd_ptr_q;
	logic [`TRACE_PTR_W:0] count_q;
	logic ovf_q;
	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full = (count_q == `TRACE_DEPTH);
	assign empty = (count_q == '0);

	// A push into a full buffer is lost, a pop from an empty one does nothing.
	assign do_push = push_i & ~full;
	assign do_pop = pop_i & ~empty;

	// Pointers wrap on their own since depth is a power of two.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	// Sticky overflow. A new loss in the clearing cycle still sets it.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ovf_q <= 1'b0;
		else if (push_i && full)
			ovf_q <= 1'b1;
		else if (ovf_clr_i)
			ovf_q <= 1'b0;
	end

	// Storage.
	always_ff @(posedge sys_clk) begin
		if (do_push)
			mem[wr_ptr_q] <= rec_i;
	end

	// Head is stale when empty, the reader masks it with the count.
	assign head_o = mem[rd_ptr_q];
	assign count_o = count_q;
	assign ovf_o = ovf_q;

endmodule

`default_nettype wire

//--- verilog/trace_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "surf_ctrl_config.svh"

module trace_reader (
	input  wire                             sys_clk,
	input  wire                             rst_n_i,
	input  wire surf_ctrl_pkg::wb_req_t     wb_req_i,
	output surf_ctrl_pkg::wb_rsp_t          wb_rsp_o,
	input  wire surf_ctrl_pkg::trace_rec_t  head_i,
	input  wire [`TRACE_PTR_W:0]            count_i,
	input  wire                             ovf_i,
	output logic                            pop_o,
	output logic                            ovf_clr_o
);

	surf_ctrl_pkg::trace_reg_e reg_off;
	logic req_new;
	logic has_rec;
	logic ack_q;
	logic pop_q;
	logic clr_q;
	logic [`WB_DAT_W-1:0] rd_dat;
	logic [`WB_DAT_W-1:0] dat_q;

	assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	assign reg_off = surf_ctrl_pkg::trace_reg_e'(wb_req_i.adr[3:2]);
	assign has_rec = (count_i != '0);

	// Read mux. Head and data read zero while the buffer is empty.
	always_comb begin
		case (reg_off)
			surf_ctrl_pkg::TRC_HEAD:
				rd_dat = has_rec ? {head_i.mid, head_i.we, head_i.err,
					{(`WB_DAT_W-3-`WB_ADR_W){1'b0}}, head_i.adr} : '0;
			surf_ctrl_pkg::TRC_DATA:
				rd_dat = has_rec ? head_i.dat : '0;
			surf_ctrl_pkg::TRC_STATUS:
				rd_dat = {ovf_i, {(`WB_DAT_W-`TRACE_PTR_W-2){1'b0}}, count_i};
			default:
				rd_dat = '0;
		endcase
	end

	// Ack, pop and clear all line up in the response cycle.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			pop_q <= 1'b0;
			clr_q <= 1'b0;
		end else begin
			ack_q <= req_new;
			pop_q <= req_new & ~wb_req_i.we & has_rec &
				(reg_off == surf_ctrl_pkg::TRC_DATA);
			clr_q <= req_new & wb_req_i.we & (reg_off == surf_ctrl_pkg::TRC_STATUS);
		end
	end

	// Read data.
	always_ff @(posedge sys_clk) begin
		if (req_new)
			dat_q <= wb_req_i.we ? '0 : rd_dat;
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.err = 1'b0;
	assign wb_rsp_o.dat = ack_q ? dat_q : '0;
	assign pop_o = pop_q;
	assign ovf_clr_o = clr_q;

endmodule

`default_nettype wire

//--- verilog/wb_trace_capture.sv
`timescale 1ns/1ps
`default_nettype none

module wb_trace_capture (
	input  wire                            sys_clk,
	input  wire                            rst_n_i,
	input  wire surf_ctrl_pkg::bus_mon_t   mon_i,
	output surf_ctrl_pkg::trace_rec_t      rec_o,
	output logic                           push_o
);

	surf_ctrl_pkg::trace_rec_t rec_q;
	logic keep;
	logic push_q;

	// Accesses to the trace window itself are never recorded.
	// Otherwise reading the trace would refill it.
	assign keep = mon_i.valid & (mon_i.target != surf_ctrl_pkg::SLV_TRACE);

	// Push strobe, one cycle per kept transfer.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			push_q <= 1'b0;
		else
			push_q <= keep;
	end

	// Record payload.
	always_ff @(posedge sys_clk) begin
		if (keep) begin
			rec_q.mid <= mon_i.mid;
			rec_q.we <= mon_i.we;
			rec_q.err <= mon_i.err;
			rec_q.adr <= mon_i.adr;
			rec_q.dat <= mon_i.dat;
		end
	end

	assign rec_o = rec_q;
	assign push_o = push_q;

endmodule

`default_nettype wire

//--- verilog/wbc_intercon.sv
`timescale 1ns/1ps
`default_nettype none

`include "surf_ctrl_config.svh"

module wbc_intercon (
	input  wire                            sys_clk,
	input  wire                            rst_n_i,
	input  wire surf_ctrl_pkg::wb_req_t    m0_req_i,
	input  wire surf_ctrl_pkg::wb_req_t    m1_req_i,
	output surf_ctrl_pkg::wb_rsp_t         m0_rsp_o,
	output surf_ctrl_pkg::wb_rsp_t         m1_rsp_o,
	output surf_ctrl_pkg::wb_req_t         id_req_o,
	input  wire surf_ctrl_pkg::wb_rsp_t    id_rsp_i,
	output surf_ctrl_pkg::wb_req_t         trace_req_o,
	input  wire surf_ctrl_pkg::wb_rsp_t    trace_rsp_i,
	output surf_ctrl_pkg::bus_mon_t        mon_o
);

	surf_ctrl_pkg::arb_state_e arb_q;
	surf_ctrl_pkg::arb_state_e owner;
	surf_ctrl_pkg::wb_req_t gnt_req;
	surf_ctrl_pkg::slave_sel_e slv_sel;
	surf_ctrl_pkg::wb_rsp_t slv_rsp;
	logic [`SLV_FIELD_HI-`SLV_FIELD_LO:0] slv_field;
	logic none_err_q;

	// Owner for this cycle.
	// From idle the grant is immediate, m0 first.
	// An owner that drops cyc loses the bus at once.
	always_comb begin
		case (arb_q)
			surf_ctrl_pkg::ARB_M0:
				owner = m0_req_i.cyc ? surf_ctrl_pkg::ARB_M0 : surf_ctrl_pkg::ARB_IDLE;
			surf_ctrl_pkg::ARB_M1:
				owner = m1_req_i.cyc ? surf_ctrl_pkg::ARB_M1 : surf_ctrl_pkg::ARB_IDLE;
			default: begin
				if (m0_req_i.cyc)
					owner = surf_ctrl_pkg::ARB_M0;
				else if (m1_req_i.cyc)
					owner = surf_ctrl_pkg::ARB_M1;
				else
					owner = surf_ctrl_pkg::ARB_IDLE;
			end
		endcase
	end

	// Returning to idle after a drop delays the next grant by one cycle.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			arb_q <= surf_ctrl_pkg::ARB_IDLE;
		else if (arb_q == surf_ctrl_pkg::ARB_IDLE)
			arb_q <= owner;
		else if (owner == surf_ctrl_pkg::ARB_IDLE)
			arb_q <= surf_ctrl_pkg::ARB_IDLE;
	end

	// Granted request.
	always_comb begin
		case (owner)
			surf_ctrl_pkg::ARB_M0: gnt_req = m0_req_i;
			surf_ctrl_pkg::ARB_M1: gnt_req = m1_req_i;
			default:               gnt_req = '0;
		endcase
	end

	// Address decode on the slave field.
	assign slv_field = gnt_req.adr[`SLV_FIELD_HI:`SLV_FIELD_LO];

	always_comb begin
		if (slv_field == `SLV_ID_CTRL_BASE)
			slv_sel = surf_ctrl_pkg::SLV_ID_CTRL;
		else if (slv_field == `SLV_TRACE_BASE)
			slv_sel = surf_ctrl_pkg::SLV_TRACE;
		else
			slv_sel = surf_ctrl_pkg::SLV_NONE;
	end

	// Both slaves see the granted request, stb only reaches the selected one.
	always_comb begin
		id_req_o = gnt_req;
		id_req_o.stb = gnt_req.stb & (slv_sel == surf_ctrl_pkg::SLV_ID_CTRL);
		trace_req_o = gnt_req;
		trace_req_o.stb = gnt_req.stb & (slv_sel == surf_ctrl_pkg::SLV_TRACE);
	end

	// Unmapped addresses get err one cycle after stb, like a registered slave.
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i)
			none_err_q <= 1'b0;
		else
			none_err_q <= gnt_req.cyc & gnt_req.stb & ~none_err_q &
				(slv_sel == surf_ctrl_pkg::SLV_NONE);
	end

	// Response mux. Data is forced to zero without ack.
	always_comb begin
		case (slv_sel)
			surf_ctrl_pkg::SLV_ID_CTRL: slv_rsp = id_rsp_i;
			surf_ctrl_pkg::SLV_TRACE:   slv_rsp = trace_rsp_i;
			default: begin
				slv_rsp = '0;
				slv_rsp.err = none_err_q;
			end
		endcase
		if (!slv_rsp.ack)
			slv_rsp.dat = '0;
	end

	// Only the owner sees the response.
	assign m0_rsp_o = (owner == surf_ctrl_pkg::ARB_M0) ? slv_rsp : '0;
	assign m1_rsp_o = (owner == surf_ctrl_pkg::ARB_M1) ? slv_rsp : '0;

	// Monitor record, valid on the ack or err cycle.
	// Writes carry the master's data, reads the data returned.
	always_comb begin
		mon_o.valid = (owner != surf_ctrl_pkg::ARB_IDLE) & (slv_rsp.ack | slv_rsp.err);
		mon_o.mid = (owner == surf_ctrl_pkg::ARB_M1);
		mon_o.target = slv_sel;
		mon_o.we = gnt_req.we;
		mon_o.err = slv_rsp.err;
		mon_o.adr = gnt_req.adr;
		mon_o.dat = gnt_req.we ? gnt_req.dat : slv_rsp.dat;
	end

endmodule

`default_nettype wire
